//--- logic/amo_pkg.sv
`default_nettype none

package amo_pkg;

    // atomic op as decoded by the core, ANOP means no atomic in flight
    typedef enum logic [3:0] {
        ANOP = 4'd0,
        LR   = 4'd1,
        SC   = 4'd2,
        SWAP = 4'd3,
        ADD  = 4'd4,
        XOR  = 4'd5,
        AND  = 4'd6,
        OR   = 4'd7,
        MIN  = 4'd8,
        MAX  = 4'd9,
        MINU = 4'd10,
        MAXU = 4'd11
    } amo_op_e;

    // core request, held stable until the cycle after hold_o falls
    typedef struct packed {
        amo_op_e     op;
        logic [31:0] addr;     // byte address, word aligned
        logic [31:0] operand;  // rs2 value
    } amo_req_t;

    // register file write-back
    typedef struct packed {
        logic        we;
        logic [31:0] data;
    } rd_wb_t;

    localparam int MEM_WORDS_DEFAULT = 64;

    localparam amo_req_t REQ_IDLE = '{
        op:      ANOP,
        addr:    32'h0,
        operand: 32'h0
    };

    localparam rd_wb_t RD_WB_IDLE = '{
        we:   1'b0,
        data: 32'h0
    };

endpackage

`default_nettype wire

//--- logic/atomic_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module atomic_ctrl (
    input  logic             clk,
    input  logic             reset_n,
    input  amo_pkg::amo_op_e op_i,
    input  logic [31:0]      addr_i,
    input  logic [31:0]      rdata_i,
    output logic             hold_o,
    output logic             mem_read_o,
    output logic             mem_write_o,
    output logic             reg_write_o,
    output logic             sc_fail_o
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_AMO,
        WAIT_LRSC,
        WRITE_AMO,
        LRSC
    } state_e;

    state_e state;
    state_e state_next;

    logic        is_lrsc;
    logic        is_sc;
    logic        sc_match;

    // reservation set by LR, cleared by any SC
    logic        res_valid;
    logic [31:0] res_addr;
    logic [31:0] res_word;

    assign is_lrsc = (op_i == amo_pkg::LR) || (op_i == amo_pkg::SC);
    assign is_sc   = (op_i == amo_pkg::SC);

    // rdata_i holds the current word by the final state
    assign sc_match = res_valid && (res_addr == addr_i) && (res_word == rdata_i);

    always_comb begin
        state_next = IDLE;
        unique case (state)
            IDLE: begin
                if (op_i == amo_pkg::ANOP) begin
                    state_next = IDLE;
                end
                else if (is_lrsc) begin
                    state_next = WAIT_LRSC;
                end
                else begin
                    state_next = WAIT_AMO;
                end
            end
            WAIT_AMO: begin
                state_next = WRITE_AMO;
            end
            WAIT_LRSC: begin
                state_next = LRSC;
            end
            WRITE_AMO: begin
                state_next = IDLE;  // next held op starts in IDLE
            end
            LRSC: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_comb begin
        hold_o      = 1'b0;
        mem_read_o  = 1'b0;
        mem_write_o = 1'b0;
        reg_write_o = 1'b0;
        sc_fail_o   = 1'b0;
        unique case (state)
            IDLE: begin
                if (op_i != amo_pkg::ANOP) begin
                    hold_o     = 1'b1;
                    mem_read_o = 1'b1;
                end
            end
            WAIT_AMO, WAIT_LRSC: begin
                hold_o     = 1'b1;
                mem_read_o = 1'b1;  // rdata valid after this edge
            end
            WRITE_AMO: begin
                mem_write_o = 1'b1;
                reg_write_o = 1'b1;
            end
            LRSC: begin
                reg_write_o = 1'b1;
                if (is_sc) begin
                    if (sc_match) begin
                        mem_write_o = 1'b1;
                    end
                    else begin
                        sc_fail_o = 1'b1;
                    end
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end
        else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_valid <= 1'b0;  // no SC can succeed before the first LR
        end
        else if (state == LRSC) begin
            if (op_i == amo_pkg::LR) begin
                res_valid <= 1'b1;
            end
            else if (is_sc) begin
                res_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == LRSC && op_i == amo_pkg::LR) begin
            res_addr <= addr_i;
            res_word <= rdata_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/amo_alu.sv
`timescale 1ns/1ps
`default_nettype none

module amo_alu (
    input  logic             [31:0] rdata_i,
    input  amo_pkg::amo_op_e        op_i,
    input  logic             [31:0] operand_i,
    input  logic                    sc_fail_i,
    input  logic                    reg_write_i,
    output logic             [31:0] wdata_o,
    output amo_pkg::rd_wb_t         rd_o
);

    logic lt_s;
    logic lt_u;

    // old word compared against rs2
    assign lt_s = $signed(rdata_i) < $signed(operand_i);
    assign lt_u = rdata_i < operand_i;

    always_comb begin
        wdata_o = rdata_i;
        unique case (op_i)
            amo_pkg::SWAP,
            amo_pkg::SC:   wdata_o = operand_i;
            amo_pkg::ADD:  wdata_o = rdata_i + operand_i;
            amo_pkg::XOR:  wdata_o = rdata_i ^ operand_i;
            amo_pkg::AND:  wdata_o = rdata_i & operand_i;
            amo_pkg::OR:   wdata_o = rdata_i | operand_i;
            amo_pkg::MIN:  wdata_o = lt_s ? rdata_i : operand_i;
            amo_pkg::MAX:  wdata_o = lt_s ? operand_i : rdata_i;
            amo_pkg::MINU: wdata_o = lt_u ? rdata_i : operand_i;
            amo_pkg::MAXU: wdata_o = lt_u ? operand_i : rdata_i;
            default:       wdata_o = rdata_i;  // ANOP and LR never write
        endcase
    end

    always_comb begin
        rd_o    = amo_pkg::RD_WB_IDLE;
        rd_o.we = reg_write_i;
        if (op_i == amo_pkg::SC) begin
            rd_o.data = {31'h0, sc_fail_i};  // 0 on success
        end
        else begin
            rd_o.data = rdata_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int MEM_WORDS = amo_pkg::MEM_WORDS_DEFAULT
) (
    input  logic        clk,
    input  logic        read_i,
    input  logic        write_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_o
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [31:0] mem [MEM_WORDS];

    logic [31:0]      word_addr;
    logic [IDX_W-1:0] idx;

    // word index wraps at the memory depth
    assign word_addr = addr_i >> 2;
    assign idx       = IDX_W'(word_addr % MEM_WORDS);

    always_ff @(posedge clk) begin
        if (write_i) begin
            mem[idx] <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (read_i) begin
            rdata_o <= mem[idx];  // held until the next read
        end
    end

endmodule

`default_nettype wire

//--- logic/atomic_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module atomic_unit_top #(
    parameter int MEM_WORDS = amo_pkg::MEM_WORDS_DEFAULT
) (
    input  logic              clk,
    input  logic              reset_n,
    input  amo_pkg::amo_req_t req_i,
    output logic              hold_o,
    output amo_pkg::rd_wb_t   rd_o
);

    logic        mem_read;
    logic        mem_write;
    logic        reg_write;
    logic        sc_fail;
    logic [31:0] rdata;
    logic [31:0] wdata;

    atomic_ctrl u_ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .op_i        (req_i.op),
        .addr_i      (req_i.addr),
        .rdata_i     (rdata),
        .hold_o      (hold_o),
        .mem_read_o  (mem_read),
        .mem_write_o (mem_write),
        .reg_write_o (reg_write),
        .sc_fail_o   (sc_fail)
    );

    amo_alu u_alu (
        .rdata_i     (rdata),
        .op_i        (req_i.op),
        .operand_i   (req_i.operand),
        .sc_fail_i   (sc_fail),
        .reg_write_i (reg_write),
        .wdata_o     (wdata),
        .rd_o        (rd_o)
    );

    // single port, address straight from the held request
    data_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_ram (
        .clk     (clk),
        .read_i  (mem_read),
        .write_i (mem_write),
        .addr_i  (req_i.addr),
        .wdata_i (wdata),
        .rdata_o (rdata)
    );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic reset_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);  // release away from the active edge
        reset_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- test/atomic_ctrl_assert.sv
`timescale 1ns/1ps
`default_nettype none

module atomic_ctrl_assert (
    input logic             clk_i,
    input logic             reset_n_i,
    input amo_pkg::amo_op_e op_i,
    input logic             hold_i,
    input logic             mem_read_i,
    input logic             mem_write_i,
    input logic             reg_write_i,
    input logic             sc_fail_i
);

    // a new op stalls for two cycles, then writes back with hold low
    hold_two_cycles: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        $rose(hold_i) |-> ##1 hold_i ##1 (!hold_i && reg_write_i))
    else $error("hold did not stay high for exactly two cycles before the write-back");

    // strobes only in the final state
    write_after_hold: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        (mem_write_i || reg_write_i) |-> (!hold_i && $past(hold_i) && $past(hold_i, 2)))
    else $error("write strobe outside the cycle after the two stall cycles");

    no_write_on_sc_fail: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        !(mem_write_i && sc_fail_i))
    else $error("memory written by a failed store-conditional");

    idle_quiet: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        (op_i == amo_pkg::ANOP) |->
            !(hold_i || mem_read_i || mem_write_i || reg_write_i || sc_fail_i))
    else $error("control output high in idle with no atomic op");

endmodule

bind atomic_ctrl atomic_ctrl_assert u_ctrl_assert (
    .clk_i       (clk),
    .reset_n_i   (reset_n),
    .op_i        (op_i),
    .hold_i      (hold_o),
    .mem_read_i  (mem_read_o),
    .mem_write_i (mem_write_o),
    .reg_write_i (reg_write_o),
    .sc_fail_i   (sc_fail_o)
);

`default_nettype wire

//--- test/atomic_tb.sv
`timescale 1ns/1ps
`default_nettype none

module atomic_tb;

    localparam int MEM_WORDS   = 64;
    localparam int IDX_W       = $clog2(MEM_WORDS);
    localparam int AMO_ROUNDS  = 4;
    localparam int B2B_OPS     = 40;
    localparam int N_OPS       = 4 + 10 + 3 + 5 + 8 * AMO_ROUNDS * 3 + 4 + B2B_OPS;
    localparam int WATCHDOG_NS = (N_OPS * 3 + 16 + 50) * 100;

    logic              clk;
    logic              reset_n;
    amo_pkg::amo_req_t req;
    logic              hold;
    amo_pkg::rd_wb_t   rd;

    // shadow memory and reservation
    logic [31:0] shadow [MEM_WORDS];
    logic        known  [MEM_WORDS];
    logic        res_valid;
    logic [31:0] res_addr;
    logic [31:0] res_word;
    logic [31:0] addr_tab [4];

    logic [31:0] rng = 32'h9508_9c0d;
    logic [31:0] exp_data;
    logic        exp_hold;
    logic        exp_we;
    logic        chk_en;
    string       cur_test;
    string       test_name;
    int          errors = 0;
    int          ops_issued = 0;
    int          we_seen = 0;

    tb_clock #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (16)
    ) u_clock (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    atomic_unit_top #(
        .MEM_WORDS (MEM_WORDS)
    ) dut (
        .clk     (clk),
        .reset_n (reset_n),
        .req_i   (req),
        .hold_o  (hold),
        .rd_o    (rd)
    );

    always @(posedge clk) begin
        if (reset_n && rd.we) begin
            we_seen <= we_seen + 1;
        end
    end

    rd_value_check: assert property (@(posedge clk) disable iff (!reset_n)
        (rd.we && chk_en) |-> (rd.data == exp_data))
    else begin
        $display("ERROR %s: expected %08h actual %08h", test_name, exp_data, $sampled(rd.data));
        errors++;
    end

    // stall level and write-back strobe, cycle by cycle within each op
    hold_we_check: assert property (@(posedge clk) disable iff (!reset_n)
        (hold == exp_hold) && (rd.we == exp_we))
    else begin
        $display("ERROR %s: expected hold %0b we %0b actual hold %0b we %0b",
                 test_name, exp_hold, exp_we, $sampled(hold), $sampled(rd.we));
        errors++;
    end

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function automatic logic [31:0] amo_result(input amo_pkg::amo_op_e op,
                                               input logic [31:0] old,
                                               input logic [31:0] opnd);
        logic signed [31:0] s_old;
        logic signed [31:0] s_opnd;
        s_old  = old;
        s_opnd = opnd;
        case (op)
            amo_pkg::SWAP: return opnd;
            amo_pkg::ADD:  return old + opnd;
            amo_pkg::XOR:  return old ^ opnd;
            amo_pkg::AND:  return old & opnd;
            amo_pkg::OR:   return old | opnd;
            amo_pkg::MIN:  return (s_opnd < s_old) ? opnd : old;
            amo_pkg::MAX:  return (s_opnd > s_old) ? opnd : old;
            amo_pkg::MINU: return (opnd < old) ? opnd : old;
            amo_pkg::MAXU: return (opnd > old) ? opnd : old;
            default:       return old;
        endcase
    endfunction

    // drives one op for three cycles and updates the model
    task automatic issue_op(input amo_pkg::amo_op_e op, input logic [31:0] addr,
                            input logic [31:0] operand);
        logic [IDX_W-1:0] idx;
        logic [31:0]      old;
        logic             sc_ok;
        idx = IDX_W'((addr >> 2) % MEM_WORDS);
        old = shadow[idx];
        @(negedge clk);
        req.op      = op;
        req.addr    = addr;
        req.operand = operand;
        test_name   = cur_test;
        exp_data    = old;
        exp_hold    = (op != amo_pkg::ANOP);
        exp_we      = 1'b0;
        chk_en      = known[idx];
        case (op)
            amo_pkg::ANOP: chk_en = 1'b0;
            amo_pkg::LR: begin
                res_valid = 1'b1;
                res_addr  = addr;
                res_word  = old;
            end
            amo_pkg::SC: begin
                sc_ok    = res_valid && (res_addr == addr) && (res_word == old);
                exp_data = sc_ok ? 32'd0 : 32'd1;
                if (sc_ok) begin
                    shadow[idx] = operand;
                end
                res_valid = 1'b0;  // any SC drops the reservation
            end
            default: begin
                shadow[idx] = amo_result(op, old, operand);
                known[idx]  = 1'b1;
            end
        endcase
        if (op != amo_pkg::ANOP) begin
            ops_issued++;
        end
        repeat (2) @(negedge clk);
        exp_hold = 1'b0;  // final cycle, write-back with the stall released
        exp_we   = (op != amo_pkg::ANOP);
    endtask

    task automatic timing_test();
        cur_test = "timing";
        issue_op(amo_pkg::ANOP, 32'h0, 32'h0);
        issue_op(amo_pkg::SWAP, 32'h10, 32'h1234_5678);
        issue_op(amo_pkg::ANOP, 32'h0, 32'h0);
        issue_op(amo_pkg::SWAP, 32'h10, next_rand());
    endtask

    task automatic sc_fail_test();
        cur_test = "sc_fail";
        issue_op(amo_pkg::SWAP, 32'h20, next_rand());
        issue_op(amo_pkg::SWAP, 32'h24, next_rand());
        issue_op(amo_pkg::SC, 32'h20, next_rand());  // no LR since reset
        issue_op(amo_pkg::LR, 32'h20, 32'h0);
        issue_op(amo_pkg::SC, 32'h24, next_rand());  // other address than the LR
        issue_op(amo_pkg::LR, 32'h24, 32'h0);
        issue_op(amo_pkg::LR, 32'h20, 32'h0);
        issue_op(amo_pkg::ADD, 32'h20, 32'd5);
        issue_op(amo_pkg::SC, 32'h20, next_rand());  // reserved word changed
        issue_op(amo_pkg::LR, 32'h20, 32'h0);
    endtask

    task automatic swap_test();
        cur_test = "swap";
        issue_op(amo_pkg::SWAP, 32'h30, next_rand());
        issue_op(amo_pkg::SWAP, 32'h30, next_rand());
        issue_op(amo_pkg::LR, 32'h30, 32'h0);
    endtask

    task automatic sc_match_test();
        cur_test = "sc_match";
        issue_op(amo_pkg::SWAP, 32'h34, next_rand());
        issue_op(amo_pkg::LR, 32'h34, 32'h0);
        issue_op(amo_pkg::SC, 32'h34, next_rand());
        issue_op(amo_pkg::SC, 32'h34, next_rand());  // second SC has no reservation
        issue_op(amo_pkg::LR, 32'h34, 32'h0);
    endtask

    task automatic amo_test();
        logic [31:0]      rv;
        logic [31:0]      old;
        logic [31:0]      opnd;
        amo_pkg::amo_op_e op;
        cur_test = "amo";
        for (int k = 4; k <= 11; k++) begin
            op = amo_pkg::amo_op_e'(k[3:0]);
            for (int r = 0; r < AMO_ROUNDS; r++) begin
                rv   = next_rand();
                old  = (r == 0) ? 32'hffff_ffff : (r == 1) ? 32'h8000_0001 : next_rand();
                opnd = (r == 1) ? 32'hffff_ffff : (r == 2) ? 32'h8000_0000 : next_rand();
                issue_op(amo_pkg::SWAP, addr_tab[rv[31:30]], old);
                issue_op(op, addr_tab[rv[31:30]], opnd);
                issue_op(amo_pkg::LR, addr_tab[rv[31:30]], 32'h0);
            end
        end
    endtask

    task automatic b2b_test();
        logic [31:0]      rv;
        amo_pkg::amo_op_e op;
        cur_test = "back_to_back";
        for (int i = 0; i < 4; i++) begin
            issue_op(amo_pkg::SWAP, addr_tab[i], next_rand());
        end
        for (int i = 0; i < B2B_OPS; i++) begin
            rv = next_rand();
            op = amo_pkg::amo_op_e'(4'd1 + 4'(rv[15:0] % 16'd11));  // LR up to MAXU
            issue_op(op, addr_tab[rv[31:30]], next_rand());
        end
    endtask

    initial begin
        req       = amo_pkg::REQ_IDLE;
        exp_data  = 32'h0;
        exp_hold  = 1'b0;
        exp_we    = 1'b0;
        chk_en    = 1'b0;
        res_valid = 1'b0;
        res_addr  = 32'h0;
        res_word  = 32'h0;
        cur_test  = "reset";
        test_name = "reset";
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = 32'h0;
            known[i]  = 1'b0;
        end
        addr_tab[0] = 32'h40;
        addr_tab[1] = 32'h44;
        addr_tab[2] = 32'h88;
        addr_tab[3] = 32'hfc;
        wait (reset_n === 1'b1);
        timing_test();
        sc_fail_test();
        swap_test();
        sc_match_test();
        amo_test();
        b2b_test();
        @(negedge clk);
        req    = amo_pkg::REQ_IDLE;
        chk_en = 1'b0;
        exp_we = 1'b0;
        repeat (2) @(negedge clk);
        we_count_check: assert (we_seen == ops_issued)
        else begin
            $display("ERROR register_writes: expected %0d actual %0d", ops_issued, we_seen);
            errors++;
        end
        $display("ops %0d, register writes %0d, errors %0d", ops_issued, we_seen, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end
        else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all atomic ops completed");
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
logic/amo_pkg.sv
logic/atomic_ctrl.sv
logic/amo_alu.sv
logic/data_ram.sv
logic/atomic_unit_top.sv
test/tb_clock.sv
test/atomic_ctrl_assert.sv
test/atomic_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the atomic unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --assert -f build.f --top-module atomic_tb -o atomic_sim \
    > "$LOG" 2>&1 \
    && ./obj_dir/atomic_sim >> "$LOG" 2>&1 \
    || echo ">>> FAIL" >> "$LOG"

cat "$LOG"

grep -q ">>> FAIL" "$LOG" && exit 1 || exit 0
